/* filelist.f */
+incdir+tb
rtl/core_pkg.sv
rtl/alu.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/forward_unit.sv
rtl/fetch_issue.sv
rtl/exec_pipe.sv
rtl/datapath.sv
tb/tb_datapath.sv

/* rtl/alu.sv */
module alu (
    input  core_pkg::alu_op_e op_i,
    input  core_pkg::word_t   a_i,
    input  core_pkg::word_t   b_i,
    output core_pkg::word_t   y_o
);

    always_comb begin
        case (op_i)
            core_pkg::ALU_ADD: y_o = a_i + b_i;
            core_pkg::ALU_SUB: y_o = a_i - b_i;
            core_pkg::ALU_AND: y_o = a_i & b_i;
            core_pkg::ALU_OR:  y_o = a_i | b_i;
            core_pkg::ALU_XOR: y_o = a_i ^ b_i;
            core_pkg::ALU_SLT: y_o = {31'd0, $signed(a_i) < $signed(b_i)};
            // shift amount comes in on a
            core_pkg::ALU_SLL: y_o = b_i << a_i[4:0];
            core_pkg::ALU_SRL: y_o = b_i >> a_i[4:0];
            core_pkg::ALU_LUI: y_o = {b_i[15:0], 16'd0};
            default:           y_o = '0;
        endcase
    end

endmodule

/* rtl/core_pkg.sv */
package core_pkg;

    parameter int NUM_REGS = 32;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI, ALU_NOP
    } alu_op_e;

    // primary opcodes, MIPS32 encoding
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f
    } opcode_e;

    // funct field of SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

endpackage

/* rtl/datapath.sv */
module datapath #(
    parameter core_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  core_pkg::word_t     inst_rdata1_i,
    input  core_pkg::word_t     inst_rdata2_i,
    input  logic                i_stall_i,
    output core_pkg::word_t     inst_addr_o,
    output logic                wb_master_wen_o,
    output core_pkg::word_t     wb_master_pc_o,
    output core_pkg::reg_addr_t wb_master_wnum_o,
    output core_pkg::word_t     wb_master_wdata_o,
    output logic                wb_slave_wen_o,
    output core_pkg::word_t     wb_slave_pc_o,
    output core_pkg::reg_addr_t wb_slave_wnum_o,
    output core_pkg::word_t     wb_slave_wdata_o
);

    logic                pair_valid, slave_issue;
    // operand slots: master rs, master rt, slave rs, slave rt
    core_pkg::reg_addr_t src [4];
    core_pkg::word_t     rf_data [4];
    core_pkg::word_t     op_value [4];
    logic [4:0]          master_shamt, slave_shamt;
    core_pkg::word_t     master_imm, slave_imm;
    core_pkg::alu_op_e   master_alu_op, slave_alu_op;
    logic                master_sel_shamt, slave_sel_shamt;
    logic                master_sel_imm, slave_sel_imm;
    core_pkg::reg_addr_t master_waddr, slave_waddr;
    logic                master_wen, slave_wen;
    logic                e_master_wen, e_slave_wen, m_master_wen, m_slave_wen;
    core_pkg::reg_addr_t e_master_waddr, e_slave_waddr, m_master_waddr, m_slave_waddr;
    core_pkg::word_t     e_master_wdata, e_slave_wdata, m_master_wdata, m_slave_wdata;

    fetch_issue #(
        .RESET_PC (RESET_PC)
    ) u_fetch_issue (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .i_stall_i          (i_stall_i),
        .master_reg_wen_i   (master_wen),
        .master_reg_waddr_i (master_waddr),
        .slave_rs_i         (src[2]),
        .slave_rt_i         (src[3]),
        .pc_o               (inst_addr_o),
        .pair_valid_o       (pair_valid),
        .slave_issue_o      (slave_issue)
    );

    decoder u_decoder_master (
        .inst_i      (inst_rdata1_i),
        .rs_o        (src[0]),
        .rt_o        (src[1]),
        .shamt_o     (master_shamt),
        .imm_value_o (master_imm),
        .alu_op_o    (master_alu_op),
        .sel_shamt_o (master_sel_shamt),
        .sel_imm_o   (master_sel_imm),
        .reg_waddr_o (master_waddr),
        .reg_wen_o   (master_wen)
    );

    decoder u_decoder_slave (
        .inst_i      (inst_rdata2_i),
        .rs_o        (src[2]),
        .rt_o        (src[3]),
        .shamt_o     (slave_shamt),
        .imm_value_o (slave_imm),
        .alu_op_o    (slave_alu_op),
        .sel_shamt_o (slave_sel_shamt),
        .sel_imm_o   (slave_sel_imm),
        .reg_waddr_o (slave_waddr),
        .reg_wen_o   (slave_wen)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (src[0]),
        .raddr2_i (src[1]),
        .raddr3_i (src[2]),
        .raddr4_i (src[3]),
        .wen1_i   (wb_master_wen_o),
        .waddr1_i (wb_master_wnum_o),
        .wdata1_i (wb_master_wdata_o),
        .wen2_i   (wb_slave_wen_o),
        .waddr2_i (wb_slave_wnum_o),
        .wdata2_i (wb_slave_wdata_o),
        .rdata1_o (rf_data[0]),
        .rdata2_o (rf_data[1]),
        .rdata3_o (rf_data[2]),
        .rdata4_o (rf_data[3])
    );

    for (genvar i = 0; i < 4; i++) begin : g_fwd
        forward_unit u_forward_unit (
            .src_i            (src[i]),
            .rf_data_i        (rf_data[i]),
            .e_slave_wen_i    (e_slave_wen),
            .e_slave_waddr_i  (e_slave_waddr),
            .e_slave_wdata_i  (e_slave_wdata),
            .e_master_wen_i   (e_master_wen),
            .e_master_waddr_i (e_master_waddr),
            .e_master_wdata_i (e_master_wdata),
            .m_slave_wen_i    (m_slave_wen),
            .m_slave_waddr_i  (m_slave_waddr),
            .m_slave_wdata_i  (m_slave_wdata),
            .m_master_wen_i   (m_master_wen),
            .m_master_waddr_i (m_master_waddr),
            .m_master_wdata_i (m_master_wdata),
            .value_o          (op_value[i])
        );
    end

    exec_pipe u_exec_pipe (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .pair_valid_i       (pair_valid),
        .slave_issue_i      (slave_issue),
        .pc_i               (inst_addr_o),
        .master_rs_value_i  (op_value[0]),
        .master_rt_value_i  (op_value[1]),
        .master_imm_i       (master_imm),
        .master_shamt_i     (master_shamt),
        .master_sel_shamt_i (master_sel_shamt),
        .master_sel_imm_i   (master_sel_imm),
        .master_alu_op_i    (master_alu_op),
        .master_waddr_i     (master_waddr),
        .master_wen_i       (master_wen),
        .slave_rs_value_i   (op_value[2]),
        .slave_rt_value_i   (op_value[3]),
        .slave_imm_i        (slave_imm),
        .slave_shamt_i      (slave_shamt),
        .slave_sel_shamt_i  (slave_sel_shamt),
        .slave_sel_imm_i    (slave_sel_imm),
        .slave_alu_op_i     (slave_alu_op),
        .slave_waddr_i      (slave_waddr),
        .slave_wen_i        (slave_wen),
        .e_master_wen_o     (e_master_wen),
        .e_master_waddr_o   (e_master_waddr),
        .e_master_wdata_o   (e_master_wdata),
        .e_slave_wen_o      (e_slave_wen),
        .e_slave_waddr_o    (e_slave_waddr),
        .e_slave_wdata_o    (e_slave_wdata),
        .m_master_wen_o     (m_master_wen),
        .m_master_waddr_o   (m_master_waddr),
        .m_master_wdata_o   (m_master_wdata),
        .m_slave_wen_o      (m_slave_wen),
        .m_slave_waddr_o    (m_slave_waddr),
        .m_slave_wdata_o    (m_slave_wdata),
        .wb_master_wen_o    (wb_master_wen_o),
        .wb_master_pc_o     (wb_master_pc_o),
        .wb_master_wnum_o   (wb_master_wnum_o),
        .wb_master_wdata_o  (wb_master_wdata_o),
        .wb_slave_wen_o     (wb_slave_wen_o),
        .wb_slave_pc_o      (wb_slave_pc_o),
        .wb_slave_wnum_o    (wb_slave_wnum_o),
        .wb_slave_wdata_o   (wb_slave_wdata_o)
    );

endmodule

/* rtl/decoder.sv */
module decoder (
    input  core_pkg::word_t     inst_i,
    output core_pkg::reg_addr_t rs_o,
    output core_pkg::reg_addr_t rt_o,
    output logic [4:0]          shamt_o,
    output core_pkg::word_t     imm_value_o,
    output core_pkg::alu_op_e   alu_op_o,
    output logic                sel_shamt_o,
    output logic                sel_imm_o,
    output core_pkg::reg_addr_t reg_waddr_o,
    output logic                reg_wen_o
);

    logic [5:0]          opcode;
    logic [5:0]          funct;
    core_pkg::reg_addr_t rd;
    logic                supported;

    assign opcode  = inst_i[31:26];
    assign rs_o    = inst_i[25:21];
    assign rt_o    = inst_i[20:16];
    assign rd      = inst_i[15:11];
    assign shamt_o = inst_i[10:6];
    assign funct   = inst_i[5:0];

    // only addiu sign-extends
    assign imm_value_o = (opcode == core_pkg::OP_ADDIU) ? {{16{inst_i[15]}}, inst_i[15:0]}
                                                        : {16'd0, inst_i[15:0]};

    always_comb begin
        alu_op_o    = core_pkg::ALU_NOP;
        sel_shamt_o = 1'b0;
        sel_imm_o   = 1'b1;
        reg_waddr_o = rt_o;
        supported   = 1'b1;
        case (opcode)
            core_pkg::OP_SPECIAL: begin
                sel_imm_o   = 1'b0;
                reg_waddr_o = rd;
                case (funct)
                    core_pkg::FN_ADDU: alu_op_o = core_pkg::ALU_ADD;
                    core_pkg::FN_SUBU: alu_op_o = core_pkg::ALU_SUB;
                    core_pkg::FN_AND:  alu_op_o = core_pkg::ALU_AND;
                    core_pkg::FN_OR:   alu_op_o = core_pkg::ALU_OR;
                    core_pkg::FN_XOR:  alu_op_o = core_pkg::ALU_XOR;
                    core_pkg::FN_SLT:  alu_op_o = core_pkg::ALU_SLT;
                    core_pkg::FN_SLL: begin
                        alu_op_o    = core_pkg::ALU_SLL;
                        sel_shamt_o = 1'b1;
                    end
                    core_pkg::FN_SRL: begin
                        alu_op_o    = core_pkg::ALU_SRL;
                        sel_shamt_o = 1'b1;
                    end
                    default: supported = 1'b0;
                endcase
            end
            core_pkg::OP_ADDIU: alu_op_o = core_pkg::ALU_ADD;
            core_pkg::OP_ORI:   alu_op_o = core_pkg::ALU_OR;
            core_pkg::OP_LUI:   alu_op_o = core_pkg::ALU_LUI;
            default:            supported = 1'b0;
        endcase
    end

    assign reg_wen_o = supported && (reg_waddr_o != '0);

endmodule

/* rtl/exec_pipe.sv */
module exec_pipe (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                pair_valid_i,
    input  logic                slave_issue_i,
    input  core_pkg::word_t     pc_i,
    input  core_pkg::word_t     master_rs_value_i,
    input  core_pkg::word_t     master_rt_value_i,
    input  core_pkg::word_t     master_imm_i,
    input  logic [4:0]          master_shamt_i,
    input  logic                master_sel_shamt_i,
    input  logic                master_sel_imm_i,
    input  core_pkg::alu_op_e   master_alu_op_i,
    input  core_pkg::reg_addr_t master_waddr_i,
    input  logic                master_wen_i,
    input  core_pkg::word_t     slave_rs_value_i,
    input  core_pkg::word_t     slave_rt_value_i,
    input  core_pkg::word_t     slave_imm_i,
    input  logic [4:0]          slave_shamt_i,
    input  logic                slave_sel_shamt_i,
    input  logic                slave_sel_imm_i,
    input  core_pkg::alu_op_e   slave_alu_op_i,
    input  core_pkg::reg_addr_t slave_waddr_i,
    input  logic                slave_wen_i,
    output logic                e_master_wen_o,
    output core_pkg::reg_addr_t e_master_waddr_o,
    output core_pkg::word_t     e_master_wdata_o,
    output logic                e_slave_wen_o,
    output core_pkg::reg_addr_t e_slave_waddr_o,
    output core_pkg::word_t     e_slave_wdata_o,
    output logic                m_master_wen_o,
    output core_pkg::reg_addr_t m_master_waddr_o,
    output core_pkg::word_t     m_master_wdata_o,
    output logic                m_slave_wen_o,
    output core_pkg::reg_addr_t m_slave_waddr_o,
    output core_pkg::word_t     m_slave_wdata_o,
    output logic                wb_master_wen_o,
    output core_pkg::word_t     wb_master_pc_o,
    output core_pkg::reg_addr_t wb_master_wnum_o,
    output core_pkg::word_t     wb_master_wdata_o,
    output logic                wb_slave_wen_o,
    output core_pkg::word_t     wb_slave_pc_o,
    output core_pkg::reg_addr_t wb_slave_wnum_o,
    output core_pkg::word_t     wb_slave_wdata_o
);

    core_pkg::word_t   master_a, master_b;
    core_pkg::word_t   slave_a, slave_b;
    core_pkg::word_t   e_pc, m_pc;
    core_pkg::word_t   e_master_a, e_master_b;
    core_pkg::word_t   e_slave_a, e_slave_b;
    core_pkg::alu_op_e e_master_op, e_slave_op;
    logic              e_master_valid, e_slave_valid;
    logic              m_master_valid, m_slave_valid;
    logic              w_master_valid, w_slave_valid;
    logic              e_master_wen, e_slave_wen;
    logic              m_master_wen, m_slave_wen;
    logic              w_master_wen, w_slave_wen;

    assign master_a = master_sel_shamt_i ? {27'd0, master_shamt_i} : master_rs_value_i;
    assign master_b = master_sel_imm_i ? master_imm_i : master_rt_value_i;
    assign slave_a  = slave_sel_shamt_i ? {27'd0, slave_shamt_i} : slave_rs_value_i;
    assign slave_b  = slave_sel_imm_i ? slave_imm_i : slave_rt_value_i;

    assign e_master_wen_o  = e_master_valid & e_master_wen;
    assign e_slave_wen_o   = e_slave_valid & e_slave_wen;
    assign m_master_wen_o  = m_master_valid & m_master_wen;
    assign m_slave_wen_o   = m_slave_valid & m_slave_wen;
    assign wb_master_wen_o = w_master_valid & w_master_wen;
    assign wb_slave_wen_o  = w_slave_valid & w_slave_wen;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            e_master_valid <= 1'b0;
            e_slave_valid  <= 1'b0;
            m_master_valid <= 1'b0;
            m_slave_valid  <= 1'b0;
            w_master_valid <= 1'b0;
            w_slave_valid  <= 1'b0;
        end else begin
            // stall or held slave enters E as a bubble
            e_master_valid <= pair_valid_i;
            e_slave_valid  <= slave_issue_i;
            m_master_valid <= e_master_valid;
            m_slave_valid  <= e_slave_valid;
            w_master_valid <= m_master_valid;
            w_slave_valid  <= m_slave_valid;
        end
    end

    always_ff @(posedge clk) begin
        e_pc             <= pc_i;
        e_master_a       <= master_a;
        e_master_b       <= master_b;
        e_master_op      <= master_alu_op_i;
        e_master_waddr_o <= master_waddr_i;
        e_master_wen     <= master_wen_i;
        e_slave_a        <= slave_a;
        e_slave_b        <= slave_b;
        e_slave_op       <= slave_alu_op_i;
        e_slave_waddr_o  <= slave_waddr_i;
        e_slave_wen      <= slave_wen_i;

        m_pc             <= e_pc;
        m_master_waddr_o <= e_master_waddr_o;
        m_master_wdata_o <= e_master_wdata_o;
        m_master_wen     <= e_master_wen;
        m_slave_waddr_o  <= e_slave_waddr_o;
        m_slave_wdata_o  <= e_slave_wdata_o;
        m_slave_wen      <= e_slave_wen;

        // slave always sits at the word after the master
        wb_master_pc_o    <= m_pc;
        wb_slave_pc_o     <= m_pc + 32'd4;
        wb_master_wnum_o  <= m_master_waddr_o;
        wb_master_wdata_o <= m_master_wdata_o;
        w_master_wen      <= m_master_wen;
        wb_slave_wnum_o   <= m_slave_waddr_o;
        wb_slave_wdata_o  <= m_slave_wdata_o;
        w_slave_wen       <= m_slave_wen;
    end

    alu u_alu_master (
        .op_i (e_master_op),
        .a_i  (e_master_a),
        .b_i  (e_master_b),
        .y_o  (e_master_wdata_o)
    );

    alu u_alu_slave (
        .op_i (e_slave_op),
        .a_i  (e_slave_a),
        .b_i  (e_slave_b),
        .y_o  (e_slave_wdata_o)
    );

    slave_with_master_a : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (!e_slave_valid || e_master_valid) &&
        (!m_slave_valid || m_master_valid) &&
        (!w_slave_valid || w_master_valid)
    );

endmodule

/* rtl/fetch_issue.sv */
module fetch_issue #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                i_stall_i,
    input  logic                master_reg_wen_i,
    input  core_pkg::reg_addr_t master_reg_waddr_i,
    input  core_pkg::reg_addr_t slave_rs_i,
    input  core_pkg::reg_addr_t slave_rt_i,
    output core_pkg::word_t     pc_o,
    output logic                pair_valid_o,
    output logic                slave_issue_o
);

    logic raw_hazard;

    assign pair_valid_o = ~i_stall_i;

    // slave reads the register the master writes
    // (master_reg_wen_i is already low for r0)
    assign raw_hazard = master_reg_wen_i &&
                        (slave_rs_i == master_reg_waddr_i || slave_rt_i == master_reg_waddr_i);

    assign slave_issue_o = pair_valid_o & ~raw_hazard;

    // a held slave is refetched as the next master
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_o <= RESET_PC;
        end else if (pair_valid_o) begin
            pc_o <= pc_o + (slave_issue_o ? 32'd8 : 32'd4);
        end
    end

    pc_aligned_a : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        pc_o[1:0] == 2'b00
    );

endmodule

/* rtl/forward_unit.sv */
module forward_unit (
    input  core_pkg::reg_addr_t src_i,
    input  core_pkg::word_t     rf_data_i,
    input  logic                e_slave_wen_i,
    input  core_pkg::reg_addr_t e_slave_waddr_i,
    input  core_pkg::word_t     e_slave_wdata_i,
    input  logic                e_master_wen_i,
    input  core_pkg::reg_addr_t e_master_waddr_i,
    input  core_pkg::word_t     e_master_wdata_i,
    input  logic                m_slave_wen_i,
    input  core_pkg::reg_addr_t m_slave_waddr_i,
    input  core_pkg::word_t     m_slave_wdata_i,
    input  logic                m_master_wen_i,
    input  core_pkg::reg_addr_t m_master_waddr_i,
    input  core_pkg::word_t     m_master_wdata_i,
    output core_pkg::word_t     value_o
);

    // newest producer first
    assign value_o = (src_i == '0)                                ? '0 :
                     (e_slave_wen_i && e_slave_waddr_i == src_i)   ? e_slave_wdata_i :
                     (e_master_wen_i && e_master_waddr_i == src_i) ? e_master_wdata_i :
                     (m_slave_wen_i && m_slave_waddr_i == src_i)   ? m_slave_wdata_i :
                     (m_master_wen_i && m_master_waddr_i == src_i) ? m_master_wdata_i :
                                                                     rf_data_i;

endmodule

/* rtl/regfile.sv */
module regfile (
    input  logic                clk,
    input  logic                rst_n_i,
    input  core_pkg::reg_addr_t raddr1_i,
    input  core_pkg::reg_addr_t raddr2_i,
    input  core_pkg::reg_addr_t raddr3_i,
    input  core_pkg::reg_addr_t raddr4_i,
    input  logic                wen1_i,
    input  core_pkg::reg_addr_t waddr1_i,
    input  core_pkg::word_t     wdata1_i,
    input  logic                wen2_i,
    input  core_pkg::reg_addr_t waddr2_i,
    input  core_pkg::word_t     wdata2_i,
    output core_pkg::word_t     rdata1_o,
    output core_pkg::word_t     rdata2_o,
    output core_pkg::word_t     rdata3_o,
    output core_pkg::word_t     rdata4_o
);

    core_pkg::word_t regs [core_pkg::NUM_REGS];

    // same-cycle write passes through, slave port first
    function automatic core_pkg::word_t read_port(input core_pkg::reg_addr_t addr);
        if (addr == '0) return '0;
        if (wen2_i && waddr2_i == addr) return wdata2_i;
        if (wen1_i && waddr1_i == addr) return wdata1_i;
        return regs[addr];
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
        rdata3_o = read_port(raddr3_i);
        rdata4_o = read_port(raddr4_i);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wen1_i) begin
                regs[waddr1_i] <= wdata1_i;
            end
            // slave is younger, so its write lands last
            if (wen2_i) begin
                regs[waddr2_i] <= wdata2_i;
            end
        end
    end

    r0_zero_a : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (wen1_i || wen2_i) |=> regs[0] == '0
    );

endmodule

/* run.sh */
#!/bin/sh
# build and run the dual-issue datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_datapath \
    -Mdir obj_dir -o tb_datapath
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_datapath > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0

/* tb/ref_model.svh */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// expected register writes in program order, one entry per write
logic [31:0] exp_pc_q [$];
logic [4:0]  exp_num_q [$];
logic [31:0] exp_data_q [$];

// register an instruction writes, r0 when it writes nothing
function automatic logic [4:0] dest_of(input logic [31:0] inst);
    case (inst[31:26])
        core_pkg::OP_SPECIAL: begin
            case (inst[5:0])
                core_pkg::FN_SLL, core_pkg::FN_SRL, core_pkg::FN_ADDU, core_pkg::FN_SUBU,
                core_pkg::FN_AND, core_pkg::FN_OR, core_pkg::FN_XOR, core_pkg::FN_SLT:
                    return inst[15:11];
                default:
                    return 5'd0;
            endcase
        end
        core_pkg::OP_ADDIU, core_pkg::OP_ORI, core_pkg::OP_LUI:
            return inst[20:16];
        default:
            return 5'd0;
    endcase
endfunction

// result of one kept instruction
function automatic logic [31:0] isa_result(input logic [31:0] inst,
                                          input logic [31:0] rs_val,
                                          input logic [31:0] rt_val);
    logic [31:0] imm_zext;
    logic [31:0] imm_sext;
    logic [4:0]  shamt;
    imm_zext = {16'd0, inst[15:0]};
    imm_sext = {{16{inst[15]}}, inst[15:0]};
    shamt    = inst[10:6];
    case (inst[31:26])
        core_pkg::OP_ADDIU: return rs_val + imm_sext;
        core_pkg::OP_ORI:   return rs_val | imm_zext;
        core_pkg::OP_LUI:   return {inst[15:0], 16'd0};
        default: ;
    endcase
    case (inst[5:0])
        core_pkg::FN_ADDU: return rs_val + rt_val;
        core_pkg::FN_SUBU: return rs_val - rt_val;
        core_pkg::FN_AND:  return rs_val & rt_val;
        core_pkg::FN_OR:   return rs_val | rt_val;
        core_pkg::FN_XOR:  return rs_val ^ rt_val;
        core_pkg::FN_SLT:  return ($signed(rs_val) < $signed(rt_val)) ? 32'd1 : 32'd0;
        core_pkg::FN_SLL:  return rt_val << shamt;
        core_pkg::FN_SRL:  return rt_val >> shamt;
        default:           return 32'd0;
    endcase
endfunction

// next word pairs unless it names the master's destination as rs or rt
function automatic logic slave_pairs(input logic [31:0] master, input logic [31:0] slave);
    logic [4:0] md;
    md = dest_of(master);
    return (md == 5'd0) || (slave[25:21] != md && slave[20:16] != md);
endfunction

// runs the program one instruction at a time
task automatic run_reference();
    logic [31:0] model_regs [core_pkg::NUM_REGS];
    logic [31:0] inst;
    logic [4:0]  rd;
    for (int r = 0; r < core_pkg::NUM_REGS; r++) begin
        model_regs[r] = '0;
    end
    for (int i = 0; i < PROG_WORDS; i++) begin
        inst = imem[i];
        rd   = dest_of(inst);
        if (rd != 5'd0) begin
            model_regs[rd] = isa_result(inst, model_regs[inst[25:21]], model_regs[inst[20:16]]);
            exp_pc_q.push_back(RESET_PC + 32'(i) * 32'd4);
            exp_num_q.push_back(rd);
            exp_data_q.push_back(model_regs[rd]);
        end
    end
endtask

`endif

/* tb/tb_datapath.sv */
module tb_datapath;

    localparam logic [31:0] RESET_PC       = 32'hbfc0_0000;
    localparam int          PROG_WORDS     = 200;
    localparam int          TIMEOUT_CYCLES = 4 * PROG_WORDS + 50;

    logic        clk;
    logic        rst_n_i;
    logic [31:0] inst_rdata1_i;
    logic [31:0] inst_rdata2_i;
    logic        i_stall_i;
    logic [31:0] inst_addr_o;
    logic        wb_master_wen_o;
    logic [31:0] wb_master_pc_o;
    logic [4:0]  wb_master_wnum_o;
    logic [31:0] wb_master_wdata_o;
    logic        wb_slave_wen_o;
    logic [31:0] wb_slave_pc_o;
    logic [4:0]  wb_slave_wnum_o;
    logic [31:0] wb_slave_wdata_o;

    logic [31:0] imem [PROG_WORDS];
    int          errors;
    int          checks;
    int          cycle_count;
    int          cycles_after_reset;

    `include "ref_model.svh"

    datapath #(
        .RESET_PC (RESET_PC)
    ) i_datapath (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .inst_rdata1_i     (inst_rdata1_i),
        .inst_rdata2_i     (inst_rdata2_i),
        .i_stall_i         (i_stall_i),
        .inst_addr_o       (inst_addr_o),
        .wb_master_wen_o   (wb_master_wen_o),
        .wb_master_pc_o    (wb_master_pc_o),
        .wb_master_wnum_o  (wb_master_wnum_o),
        .wb_master_wdata_o (wb_master_wdata_o),
        .wb_slave_wen_o    (wb_slave_wen_o),
        .wb_slave_pc_o     (wb_slave_pc_o),
        .wb_slave_wnum_o   (wb_slave_wnum_o),
        .wb_slave_wdata_o  (wb_slave_wdata_o)
    );

    always #50 clk = ~clk;

    // words past the program read as zero, a no-op
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int index;
        index = int'((addr - RESET_PC) >> 2);
        if (index >= 0 && index < PROG_WORDS) begin
            return imem[index];
        end
        return 32'd0;
    endfunction

    always_comb begin
        inst_rdata1_i = fetch_word(inst_addr_o);
        inst_rdata2_i = fetch_word(inst_addr_o + 32'd4);
    end

    // small register pool keeps dependencies close
    function automatic logic [4:0] pick_reg();
        return 5'($urandom_range(5, 0));
    endfunction

    function automatic logic [31:0] random_inst();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [15:0] imm;
        rs  = pick_reg();
        rt  = pick_reg();
        rd  = pick_reg();
        sa  = 5'($urandom());
        imm = 16'($urandom());
        case ($urandom_range(13, 0))
            0:  return {core_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, core_pkg::FN_ADDU};
            1:  return {core_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, core_pkg::FN_SUBU};
            2:  return {core_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, core_pkg::FN_AND};
            3:  return {core_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, core_pkg::FN_OR};
            4:  return {core_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, core_pkg::FN_XOR};
            5:  return {core_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, core_pkg::FN_SLT};
            6:  return {core_pkg::OP_SPECIAL, 5'd0, rt, rd, sa, core_pkg::FN_SLL};
            7:  return {core_pkg::OP_SPECIAL, 5'd0, rt, rd, sa, core_pkg::FN_SRL};
            9:  return {core_pkg::OP_ORI, rs, rt, imm};
            10: return {core_pkg::OP_LUI, 5'd0, rt, imm};
            // lw and jr, both outside the kept set
            11: return {6'h23, rs, rt, imm};
            12: return {core_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, 6'h08};
            default: return {core_pkg::OP_ADDIU, rs, rt, imm};
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic retire_writeback(input string lane, input logic [31:0] pc,
                                    input logic [4:0] num, input logic [31:0] data);
        if (exp_pc_q.size() == 0) begin
            errors++;
            $display("Error at %0t: %s lane wrote r%0d at pc %h after all expected writes",
                     $time, lane, num, pc);
        end else begin
            check_value({lane, " pc"}, pc, exp_pc_q.pop_front());
            check_value({lane, " register"}, 32'(num), 32'(exp_num_q.pop_front()));
            check_value({lane, " data"}, data, exp_data_q.pop_front());
        end
    endtask

    // outputs come from flops, so the falling edge is a quiet point
    always @(negedge clk) begin
        if (rst_n_i) begin
            cycles_after_reset++;
        end
        if (!rst_n_i) begin
            check_value("fetch address in reset", inst_addr_o, RESET_PC);
        end
        // no pair can reach W before the fourth cycle out of reset
        if (!rst_n_i || cycles_after_reset <= 3) begin
            check_value("master wen before first retirement", 32'(wb_master_wen_o), 32'd0);
            check_value("slave wen before first retirement", 32'(wb_slave_wen_o), 32'd0);
        end
        if (wb_master_wen_o === 1'b1) begin
            retire_writeback("master", wb_master_pc_o, wb_master_wnum_o, wb_master_wdata_o);
            if (dest_of(fetch_word(wb_master_pc_o + 32'd4)) != 5'd0) begin
                check_value("slave issued beside master", 32'(wb_slave_wen_o),
                            32'(slave_pairs(fetch_word(wb_master_pc_o),
                                            fetch_word(wb_master_pc_o + 32'd4))));
            end
        end
        if (wb_slave_wen_o === 1'b1) begin
            retire_writeback("slave", wb_slave_pc_o, wb_slave_wnum_o, wb_slave_wdata_o);
        end
    end

    initial begin
        clk                = 1'b0;
        rst_n_i            = 1'b0;
        i_stall_i          = 1'b0;
        errors             = 0;
        checks             = 0;
        cycle_count        = 0;
        cycles_after_reset = 0;
        void'($urandom(32'h2d4));
        for (int i = 0; i < PROG_WORDS; i++) begin
            imem[i] = random_inst();
        end
        run_reference();

        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        while (exp_pc_q.size() != 0 && cycle_count < TIMEOUT_CYCLES) begin
            i_stall_i = ($urandom_range(3, 0) == 0);
            @(posedge clk);
            #1;
            cycle_count++;
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            errors++;
            $display("Timeout: run stopped after %0d cycles", cycle_count);
        end

        // a few more cycles to catch duplicated writebacks
        i_stall_i = 1'b0;
        repeat (10) @(posedge clk);
        if (exp_pc_q.size() != 0) begin
            errors++;
            $display("Error: %0d expected writebacks never appeared", exp_pc_q.size());
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
